// ==== Makefile ====
# Verilator simulation of the clock board
VERILATOR ?= verilator
TOP       ?= tbClkBoard
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
+incdir+testbench
verilog/clkPkg.sv
verilog/clkFuncDecode.sv
verilog/clkConfigRegs.sv
verilog/clkBurstCounter.sv
verilog/clkGate.sv
verilog/clkErrorCapture.sv
verilog/clkDiagRead.sv
verilog/clkBoard.sv
testbench/clkGen.sv
testbench/tbClkBoard.sv

// ==== testbench/clkGen.sv ====
// Testbench clock and reset source
// 100 ns board clock, reset held high for the first 5 cycles
module clkGen (
  output logic CLK,
  output logic FPGA_RESET
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ClkPeriod   = 100;
  localparam int ResetCycles = 5;

  initial begin
    CLK = 1'b0;
    forever #(ClkPeriod / 2) CLK = ~CLK;
  end

  initial begin
    FPGA_RESET = 1'b1;
    repeat (ResetCycles) @(posedge CLK);
    @(negedge CLK);
    FPGA_RESET = 1'b0;   // Released on a falling edge
  end

endmodule

// ==== testbench/tbTests.svh ====
// Directed clock board tests
// Each task drives one behavior over the diagnostic bus and checks it
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

task automatic resetTest();
  int errBase;
  diagDataT word;
  errBase = errors;
  for (int sel = 0; sel < 5; sel++) begin
    readWord(diagSelT'(sel), word);
    checkWord($sformatf("word %0d", sel), word, '0);
  end
  base = pulses;
  waitCycles(20);
  for (int i = 0; i < 4; i++) checkPulses(clkName[i], i, 0, 0);
  checkLevel("mrReset", mrReset, 1'b0);
  finishTest("reset", errBase);
endtask

task automatic configTest();
  int errBase;
  logic [1:0] rate;
  logic [2:0] dis;
  logic [2:0] chk;
  logic stopEn;
  diagDataT word;
  errBase = errors;
  rate   = 2'(randBits(2));
  dis    = 3'(randBits(3));
  chk    = 3'(randBits(3));
  stopEn = 1'(randBits(1));
  loadField(FuncLdRate, {2'b00, rate});
  loadField(FuncLdDisable, {1'b0, dis});
  loadField(FuncLdCheck, {chk, 1'b0});
  loadField(FuncLdMisc, {3'b000, stopEn});
  readWord(ReadConfig, word);
  checkWord("config word", word, {rate, dis, stopEn});
  readWord(ReadParity, word);
  checkWord("parity word", word, {chk, 3'b000});   // No errors with good parity
  finishTest("config load", errBase);
endtask

task automatic burstTest();
  int errBase;
  int length;
  logic [2:0] dis;
  burstCountT count;
  errBase = errors;
  for (int rate = 0; rate < 4; rate++) begin
    length = randBits(6) % 40 + 1;
    dis    = 3'(randBits(3));
    loadField(FuncLdRate, {2'b00, 2'(rate)});
    loadField(FuncLdDisable, {1'b0, dis});
    loadField(FuncLdBurstLsb, 4'(length));
    loadField(FuncLdBurstMsb, 4'(length >> 4));
    readCount(count);
    checkCount("loaded count", count, burstCountT'(length));
    base = pulses;
    controlFunc(FuncBurst);
    // Count only falls, so the high field empties first
    waitField(ReadBurstHigh, 6'b111111, '0, length * 10 + 20, "burst count high bits");
    waitField(ReadMode, 6'b110000, '0, 40, "burst count low bits");
    waitCycles(10);   // Room for a stray extra pulse
    controlFunc(FuncStop);
    readCount(count);
    checkCount("final count", count, '0);
    checkPulses("eboxClk", 0, length, length);
    for (int i = 1; i < 4; i++) begin
      checkPulses(clkName[i], i, dis[3 - i] ? 0 : length, dis[3 - i] ? 0 : length);
    end
  end
  finishTest("burst", errBase);
endtask

task automatic stepTest();
  int errBase;
  diagDataT word;
  errBase = errors;
  base = pulses;
  controlFunc(FuncSingleStep);
  waitField(ReadMode, 6'b000010, '0, 20, "stepPending to clear");
  waitCycles(10);
  checkPulses("eboxClk", 0, 1, 1);
  readWord(ReadMode, word);
  checkWord("mode word", word, '0);
  finishTest("single step", errBase);
endtask

task automatic runTest();
  int errBase;
  int expected;
  errBase = errors;
  for (int rate = 0; rate < 4; rate++) begin
    expected = 64 >> rate;
    loadField(FuncLdRate, {2'b00, 2'(rate)});
    controlFunc(FuncStart);
    base = pulses;
    waitCycles(64);
    checkPulses($sformatf("eboxClk at rate %0d", rate), 0, expected - 1, expected + 1);
    controlFunc(FuncStop);
    waitCycles(2);   // Last pulse drains
    base = pulses;
    waitCycles(16);
    checkPulses("eboxClk after stop", 0, 0, 0);
  end
  finishTest("free run", errBase);
endtask

task automatic errorStopTest();
  int errBase;
  diagDataT word;
  errBase = errors;
  loadField(FuncLdRate, 4'b0000);
  loadField(FuncLdCheck, 4'b0010);   // DRAM check only
  loadField(FuncLdMisc, 4'b0001);
  dramParityOdd = 1'b0;
  controlFunc(FuncStart);
  waitField(ReadError, 6'b100000, 6'b100000, 20, "the error flag");
  readWord(ReadError, word);
  checkWord("error word", word, 6'b110000);
  @(negedge CLK);
  diagRead = 1'b0;   // Bus released
  #(ClkPeriod / 4);
  checkLevel("ebusDrive", ebusDrive, 1'b0);
  checkWord("ebusOut released", ebusOut, '0);
  readWord(ReadParity, word);
  checkWord("parity word", word, 6'b001001);
  base = pulses;
  waitCycles(16);
  checkPulses("eboxClk on error stop", 0, 0, 0);
  controlFunc(FuncStop);
  dramParityOdd = 1'b1;
  controlFunc(FuncSetReset);
  readWord(ReadMode, word);
  checkWord("mode word in reset", word, 6'b000001);
  checkLevel("mrReset", mrReset, 1'b1);
  controlFunc(FuncClrReset);
  readWord(ReadError, word);
  checkWord("error word after reset", word, '0);
  checkLevel("mrReset", mrReset, 1'b0);
  readWord(ReadParity, word);
  checkWord("parity word after reset", word, 6'b001000);
  finishTest("error stop", errBase);
endtask

`endif

// ==== testbench/tbClkBoard.sv ====
// Clock board testbench
// Directed tests over the diagnostic bus, pulse counters on the
// processor and section clocks, and a closing summary
module tbClkBoard;
  timeunit 1ns;
  timeprecision 100ps;
  import clkPkg::*;

  localparam int ClkPeriod  = 100;
  localparam int TestCycles = 30 + 20 + 4 * 360 + 40 + 4 * 100 + 80;   // Per-test estimates
  localparam int Margin     = 1000;

  logic CLK, FPGA_RESET, diagCtlFunc, diagLdFunc, diagRead;
  logic dramParityOdd, cramParityOdd, fmParityOdd;
  logic eboxClk, clkCrm, clkEdp, clkCtl, mrReset, ebusDrive;
  diagSelT  diagSel;
  ebusWordT ebusData;
  diagDataT ebusOut;
  logic [15:0] lfsr = 16'd31593;
  int errors = 0;
  int checks = 0;
  int testsRun = 0;
  int testsFailed = 0;
  int pulses[4] = '{default: 0};   // eboxClk, clkCrm, clkEdp, clkCtl
  int base[4] = '{default: 0};
  string clkName[4] = '{"eboxClk", "clkCrm", "clkEdp", "clkCtl"};

  clkGen i_clkGen (.CLK, .FPGA_RESET);

  clkBoard i_clkBoard (
    .CLK, .FPGA_RESET, .diagCtlFunc, .diagLdFunc, .diagSel, .ebusData, .diagRead,
    .dramParityOdd, .cramParityOdd, .fmParityOdd,
    .eboxClk, .clkCrm, .clkEdp, .clkCtl, .mrReset, .ebusDrive, .ebusOut
  );

  // Sampled a quarter period after the launching edge
  always @(posedge CLK) begin
    #(ClkPeriod / 4);
    if (eboxClk) pulses[0]++;
    if (clkCrm) pulses[1]++;
    if (clkEdp) pulses[2]++;
    if (clkCtl) pulses[3]++;
  end

  // Galois LFSR, taps 16 14 13 11
  function automatic logic lfsrBit();
    logic outBit;
    outBit = lfsr[0];
    lfsr = lfsr >> 1;
    if (outBit) lfsr = lfsr ^ 16'hB400;
    return outBit;
  endfunction

  function automatic int randBits(int width);
    int value;
    value = 0;
    for (int i = 0; i < width; i++) value = (value << 1) | int'(lfsrBit());
    return value;
  endfunction

  task automatic waitCycles(int n);
    repeat (n) @(negedge CLK);
  endtask

  task automatic controlFunc(diagSelT sel);
    @(negedge CLK);
    diagSel     = sel;
    diagCtlFunc = 1'b1;
    @(negedge CLK);
    diagCtlFunc = 1'b0;
  endtask

  task automatic loadField(diagSelT sel, logic [3:0] nibble);
    @(negedge CLK);
    diagSel         = sel;
    ebusData        = '0;
    ebusData[32:35] = nibble;   // Bit 32 is the nibble MSB
    diagLdFunc      = 1'b1;
    @(negedge CLK);
    diagLdFunc = 1'b0;
  endtask

  task automatic readWord(diagSelT sel, output diagDataT word);
    @(negedge CLK);
    diagSel  = sel;
    diagRead = 1'b1;
    #(ClkPeriod / 4);
    word = ebusOut;
    checkLevel("ebusDrive", ebusDrive, 1'b1);
  endtask

  task automatic readCount(output burstCountT count);
    diagDataT high;
    diagDataT mode;
    readWord(ReadBurstHigh, high);
    readWord(ReadMode, mode);
    count = {high, mode[5:4]};
  endtask

  task automatic waitField(diagSelT sel, diagDataT mask, diagDataT value, int limit,
                           string what);
    diagDataT word;
    readWord(sel, word);
    while ((word & mask) != value && limit > 0) begin
      readWord(sel, word);
      limit--;
    end
    if ((word & mask) != value) begin
      $display("ERROR at %0t ns: timed out waiting for %s", $time, what);
      errors++;
    end
  endtask

  task automatic checkLevel(string name, logic got, logic expected);
    checks++;
    if (got !== expected) begin
      $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, got, expected);
      errors++;
    end
  endtask

  task automatic checkWord(string name, diagDataT got, diagDataT expected);
    checks++;
    if (got !== expected) begin
      $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, got, expected);
      errors++;
    end
  endtask

  task automatic checkCount(string name, burstCountT got, burstCountT expected);
    checks++;
    if (got !== expected) begin
      $display("FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, expected);
      errors++;
    end
  endtask

  task automatic checkPulses(string name, int idx, int low, int high);
    int got;
    got = pulses[idx] - base[idx];
    checks++;
    if (got < low || got > high) begin
      $display("FAILED at %0t ns: %s pulses = %0d, expected %0d to %0d",
               $time, name, got, low, high);
      errors++;
    end
  endtask

  task automatic finishTest(string name, int errorsBefore);
    testsRun++;
    if (errors != errorsBefore) testsFailed++;
    $display("%s: %s", name, (errors == errorsBefore) ? "passed" : "failed");
  endtask

  `include "tbTests.svh"

  initial begin
    diagCtlFunc   = 1'b0;
    diagLdFunc    = 1'b0;
    diagRead      = 1'b0;
    diagSel       = '0;
    ebusData      = '0;
    dramParityOdd = 1'b1;   // Good parity
    cramParityOdd = 1'b1;
    fmParityOdd   = 1'b1;
    @(negedge FPGA_RESET);
    resetTest();
    configTest();
    burstTest();
    stepTest();
    runTest();
    errorStopTest();
    waitCycles(2);
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             testsRun, testsFailed, checks, errors);
    if (errors == 0) $display("TEST RESULT: PASS");
    else $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    #(ClkPeriod * (TestCycles + Margin));
    $display("ERROR: watchdog expired after %0d cycles", TestCycles + Margin);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== verilog/clkBoard.sv ====
// Clock control board top
// Ties function decode, config registers, burst counter, tick gate,
// parity error capture and diagnostic readback together
module clkBoard (
  input  logic              CLK,
  input  logic              FPGA_RESET,
  input  logic              diagCtlFunc,
  input  logic              diagLdFunc,
  input  clkPkg::diagSelT   diagSel,
  input  clkPkg::ebusWordT  ebusData,
  input  logic              diagRead,
  input  logic              dramParityOdd,
  input  logic              cramParityOdd,
  input  logic              fmParityOdd,
  output logic              eboxClk,
  output logic              clkCrm,
  output logic              clkEdp,
  output logic              clkCtl,
  output logic              mrReset,
  output logic              ebusDrive,
  output clkPkg::diagDataT  ebusOut
);
  import clkPkg::*;

  logic go, burst, stepPending;
  logic ldBurstLsb, ldBurstMsb, ldRate, ldDisable, ldCheck, ldMisc;
  logic crmDis, edpDis, ctlDis;
  logic fmParCheck, cramParCheck, dramParCheck, errStopEn;
  logic dramParErr, cramParErr, fmParErr, error, errorStop;
  logic burstZero;
  burstCountT burstCount;
  rateSelT    rateSel;

  clkFuncDecode i_clkFuncDecode (
    .CLK, .FPGA_RESET, .diagCtlFunc, .diagLdFunc, .diagSel, .eboxClk,
    .go, .burst, .stepPending, .mrReset,
    .ldBurstLsb, .ldBurstMsb, .ldRate, .ldDisable, .ldCheck, .ldMisc
  );

  clkConfigRegs i_clkConfigRegs (
    .CLK, .FPGA_RESET, .ldRate, .ldDisable, .ldCheck, .ldMisc, .ebusData,
    .rateSel, .crmDis, .edpDis, .ctlDis,
    .fmParCheck, .cramParCheck, .dramParCheck, .errStopEn
  );

  clkBurstCounter i_clkBurstCounter (
    .CLK, .FPGA_RESET, .ldBurstLsb, .ldBurstMsb, .ebusData, .burst, .eboxClk,
    .burstCount, .burstZero
  );

  clkGate i_clkGate (
    .CLK, .FPGA_RESET, .rateSel, .ldRate, .go, .burst, .burstZero, .stepPending,
    .errorStop, .crmDis, .edpDis, .ctlDis,
    .eboxClk, .clkCrm, .clkEdp, .clkCtl
  );

  clkErrorCapture i_clkErrorCapture (
    .CLK, .FPGA_RESET, .mrReset, .eboxClk,
    .dramParityOdd, .cramParityOdd, .fmParityOdd,
    .dramParCheck, .cramParCheck, .fmParCheck, .errStopEn,
    .dramParErr, .cramParErr, .fmParErr, .error, .errorStop
  );

  clkDiagRead i_clkDiagRead (
    .diagRead, .diagSel, .burstCount, .go, .burst, .stepPending, .mrReset,
    .rateSel, .crmDis, .edpDis, .ctlDis, .errStopEn,
    .fmParCheck, .cramParCheck, .dramParCheck,
    .fmParErr, .cramParErr, .dramParErr, .error, .errorStop,
    .ebusOut, .ebusDrive
  );

endmodule

// ==== verilog/clkBurstCounter.sv ====
// Burst counter
// Eight bits loaded a nibble at a time, counted down by each
// processor clock tick while burst mode is on
module clkBurstCounter (
  input  logic                CLK,
  input  logic                FPGA_RESET,
  input  logic                ldBurstLsb,
  input  logic                ldBurstMsb,
  input  clkPkg::ebusWordT    ebusData,
  input  logic                burst,
  input  logic                eboxClk,
  output clkPkg::burstCountT  burstCount,
  output logic                burstZero
);
  import clkPkg::*;

  loadWordT ldWord;

  assign ldWord    = ebusData[32:35];
  assign burstZero = (burstCount == '0);

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      burstCount <= '0;
    end else if (ldBurstLsb) begin
      burstCount[3:0] <= ldWord.nibble;
    end else if (ldBurstMsb) begin
      burstCount[7:4] <= ldWord.nibble;
    end else if (burst && eboxClk && !burstZero) begin
      burstCount <= burstCount - 8'd1;   // One tick used
    end
  end

endmodule

// ==== verilog/clkConfigRegs.sv ====
// Clock board configuration registers
// Rate select, section clock disables, parity check enables and the
// error-stop enable, loaded by functions 044 to 047
module clkConfigRegs (
  input  logic              CLK,
  input  logic              FPGA_RESET,
  input  logic              ldRate,
  input  logic              ldDisable,
  input  logic              ldCheck,
  input  logic              ldMisc,
  input  clkPkg::ebusWordT  ebusData,
  output clkPkg::rateSelT   rateSel,
  output logic              crmDis,
  output logic              edpDis,
  output logic              ctlDis,
  output logic              fmParCheck,
  output logic              cramParCheck,
  output logic              dramParCheck,
  output logic              errStopEn
);
  import clkPkg::*;

  loadWordT ldWord;

  assign ldWord = ebusData[32:35];

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      rateSel      <= '0;
      crmDis       <= 1'b0;
      edpDis       <= 1'b0;
      ctlDis       <= 1'b0;
      fmParCheck   <= 1'b0;
      cramParCheck <= 1'b0;
      dramParCheck <= 1'b0;
      errStopEn    <= 1'b0;
    end else begin
      if (ldRate) rateSel <= ldWord.rate.rateSel;   // 044
      if (ldDisable) begin                            // 045
        crmDis <= ldWord.dis.crmDis;
        edpDis <= ldWord.dis.edpDis;
        ctlDis <= ldWord.dis.ctlDis;
      end
      if (ldCheck) begin                              // 046
        fmParCheck   <= ldWord.check.fmCheck;
        cramParCheck <= ldWord.check.cramCheck;
        dramParCheck <= ldWord.check.dramCheck;
      end
      if (ldMisc) errStopEn <= ldWord.misc.errStopEn; // 047
    end
  end

endmodule

// ==== verilog/clkDiagRead.sv ====
// Diagnostic readback
// Puts the selected status word on data bits 30 to 35 while the
// diagnostic read level is up
module clkDiagRead (
  input  logic                diagRead,
  input  clkPkg::diagSelT     diagSel,
  input  clkPkg::burstCountT  burstCount,
  input  logic                go,
  input  logic                burst,
  input  logic                stepPending,
  input  logic                mrReset,
  input  clkPkg::rateSelT     rateSel,
  input  logic                crmDis,
  input  logic                edpDis,
  input  logic                ctlDis,
  input  logic                errStopEn,
  input  logic                fmParCheck,
  input  logic                cramParCheck,
  input  logic                dramParCheck,
  input  logic                fmParErr,
  input  logic                cramParErr,
  input  logic                dramParErr,
  input  logic                error,
  input  logic                errorStop,
  output clkPkg::diagDataT    ebusOut,
  output logic                ebusDrive
);
  import clkPkg::*;

  assign ebusDrive = diagRead;

  always_comb begin
    ebusOut = '0;
    if (diagRead) begin
      case (diagSel)
        ReadBurstHigh: ebusOut = burstCount[7:2];
        ReadMode:      ebusOut = {burstCount[1:0], go, burst, stepPending, mrReset};
        ReadConfig:    ebusOut = {rateSel, crmDis, edpDis, ctlDis, errStopEn};
        ReadParity:    ebusOut = {fmParCheck, cramParCheck, dramParCheck,
                                  fmParErr, cramParErr, dramParErr};
        ReadError:     ebusOut = {error, errorStop, 4'b0000};
        default:       ebusOut = '0;   // Selects 5..7 unused
      endcase
    end
  end

endmodule

// ==== verilog/clkErrorCapture.sv ====
// Parity error capture
// Sticky DRAM, CRAM and FM parity error latches sampled on each
// processor tick, with the optional stop on error
module clkErrorCapture (
  input  logic CLK,
  input  logic FPGA_RESET,
  input  logic mrReset,
  input  logic eboxClk,
  input  logic dramParityOdd,
  input  logic cramParityOdd,
  input  logic fmParityOdd,
  input  logic dramParCheck,
  input  logic cramParCheck,
  input  logic fmParCheck,
  input  logic errStopEn,
  output logic dramParErr,
  output logic cramParErr,
  output logic fmParErr,
  output logic error,
  output logic errorStop
);

  always_ff @(posedge CLK) begin
    if (FPGA_RESET || mrReset) begin     // Master reset clears errors too
      dramParErr <= 1'b0;
      cramParErr <= 1'b0;
      fmParErr   <= 1'b0;
    end else if (eboxClk) begin
      // Odd parity is good parity
      if (dramCheckFail()) dramParErr <= 1'b1;
      if (!cramParityOdd && cramParCheck) cramParErr <= 1'b1;
      if (!fmParityOdd && fmParCheck) fmParErr <= 1'b1;
    end
  end

  function automatic logic dramCheckFail();
    return !dramParityOdd && dramParCheck;
  endfunction

  assign error     = dramParErr || cramParErr || fmParErr;
  assign errorStop = error && errStopEn;

endmodule

// ==== verilog/clkFuncDecode.sv ====
// Diagnostic function decoder
// Turns control functions into run mode and reset flags, and
// load functions into one-cycle load strobes
module clkFuncDecode (
  input  logic             CLK,
  input  logic             FPGA_RESET,
  input  logic             diagCtlFunc,
  input  logic             diagLdFunc,
  input  clkPkg::diagSelT  diagSel,
  input  logic             eboxClk,
  output logic             go,
  output logic             burst,
  output logic             stepPending,
  output logic             mrReset,
  output logic             ldBurstLsb,
  output logic             ldBurstMsb,
  output logic             ldRate,
  output logic             ldDisable,
  output logic             ldCheck,
  output logic             ldMisc
);
  import clkPkg::*;

  logic funcStop, funcStart, funcStep, funcBurst, funcClrReset, funcSetReset;

  assign funcStop     = diagCtlFunc && (diagSel == FuncStop);
  assign funcStart    = diagCtlFunc && (diagSel == FuncStart);
  assign funcStep     = diagCtlFunc && (diagSel == FuncSingleStep);
  assign funcBurst    = diagCtlFunc && (diagSel == FuncBurst);
  assign funcClrReset = diagCtlFunc && (diagSel == FuncClrReset);
  assign funcSetReset = diagCtlFunc && (diagSel == FuncSetReset);

  assign ldBurstLsb = diagLdFunc && (diagSel == FuncLdBurstLsb);   // 042
  assign ldBurstMsb = diagLdFunc && (diagSel == FuncLdBurstMsb);   // 043
  assign ldRate     = diagLdFunc && (diagSel == FuncLdRate);
  assign ldDisable  = diagLdFunc && (diagSel == FuncLdDisable);
  assign ldCheck    = diagLdFunc && (diagSel == FuncLdCheck);
  assign ldMisc     = diagLdFunc && (diagSel == FuncLdMisc);      // 047

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      go          <= 1'b0;
      burst       <= 1'b0;
      stepPending <= 1'b0;
      mrReset     <= 1'b0;
    end else begin
      // Run mode, go and burst are exclusive
      if (funcStart) begin
        go    <= 1'b1;
        burst <= 1'b0;
      end else if (funcBurst) begin
        go    <= 1'b0;
        burst <= 1'b1;
      end else if (funcStop) begin
        go    <= 1'b0;
        burst <= 1'b0;
      end

      if (funcStep) stepPending <= 1'b1;
      else if (eboxClk) stepPending <= 1'b0;     // Step consumed

      if (funcSetReset) mrReset <= 1'b1;
      else if (funcClrReset) mrReset <= 1'b0;
    end
  end

endmodule

// ==== verilog/clkGate.sv ====
// Processor clock gate
// Rate divider plus the run, burst and single step conditions that
// let a tick through as eboxClk, and the per-section clock copies
module clkGate (
  input  logic             CLK,
  input  logic             FPGA_RESET,
  input  clkPkg::rateSelT  rateSel,
  input  logic             ldRate,
  input  logic             go,
  input  logic             burst,
  input  logic             burstZero,
  input  logic             stepPending,
  input  logic             errorStop,
  input  logic             crmDis,
  input  logic             edpDis,
  input  logic             ctlDis,
  output logic             eboxClk,
  output logic             clkCrm,
  output logic             clkEdp,
  output logic             clkCtl
);

  logic [2:0] divCount;
  logic       rateTick;
  logic       tickEn;
  logic       fire;

  // Terminal count for periods of 1, 2, 4 and 8
  always_comb begin
    case (rateSel)
      2'd0:    rateTick = 1'b1;
      2'd1:    rateTick = divCount[0];
      2'd2:    rateTick = &divCount[1:0];
      default: rateTick = &divCount;
    endcase
  end

  // Burst and step wait out the cycle of their own pulse, since the
  // count and the pending flag only update behind it
  assign tickEn = go ||
                  (burst && !burstZero && !eboxClk) ||
                  (stepPending && !eboxClk);
  assign fire = rateTick && !errorStop && tickEn;

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      divCount <= '0;
      eboxClk  <= 1'b0;
      clkCrm   <= 1'b0;
      clkEdp   <= 1'b0;
      clkCtl   <= 1'b0;
    end else begin
      if (ldRate) divCount <= '0;         // Restart on new rate
      else divCount <= divCount + 3'd1;
      eboxClk <= fire;
      clkCrm  <= fire && !crmDis;
      clkEdp  <= fire && !edpDis;
      clkCtl  <= fire && !ctlDis;
    end
  end

endmodule

// ==== verilog/clkPkg.sv ====
// Clock board shared definitions
// Diagnostic function codes, field widths, readback selects and the
// 4-bit load word as seen by functions 042 to 047
package clkPkg;

  typedef logic [0:35] ebusWordT;       // Bit 0 is the MSB
  typedef logic [2:0]  diagSelT;
  typedef logic [7:0]  burstCountT;
  typedef logic [1:0]  rateSelT;
  typedef logic [5:0]  diagDataT;       // Lands on data bits 30..35

  // Control functions 000 to 007
  localparam diagSelT FuncStop       = 3'd0;
  localparam diagSelT FuncStart      = 3'd1;
  localparam diagSelT FuncSingleStep = 3'd2;
  localparam diagSelT FuncBurst      = 3'd3;
  localparam diagSelT FuncClrReset   = 3'd6;
  localparam diagSelT FuncSetReset   = 3'd7;

  // Load functions 040 to 047
  localparam diagSelT FuncLdBurstLsb = 3'd2;
  localparam diagSelT FuncLdBurstMsb = 3'd3;
  localparam diagSelT FuncLdRate     = 3'd4;
  localparam diagSelT FuncLdDisable  = 3'd5;
  localparam diagSelT FuncLdCheck    = 3'd6;
  localparam diagSelT FuncLdMisc     = 3'd7;

  // Readback word selects
  localparam diagSelT ReadBurstHigh = 3'd0;
  localparam diagSelT ReadMode      = 3'd1;
  localparam diagSelT ReadConfig    = 3'd2;
  localparam diagSelT ReadParity    = 3'd3;
  localparam diagSelT ReadError     = 3'd4;

  // Data bits 32..35 of a load function
  typedef struct packed {logic [1:0] unused; rateSelT rateSel;} rateLoadT;
  typedef struct packed {logic unused; logic crmDis; logic edpDis; logic ctlDis;} disLoadT;
  typedef struct packed {logic fmCheck; logic cramCheck; logic dramCheck; logic unused;} chkLoadT;
  typedef struct packed {logic [2:0] unused; logic errStopEn;} miscLoadT;

  typedef union packed {
    rateLoadT   rate;     // 044
    disLoadT    dis;      // 045
    chkLoadT    check;    // 046
    miscLoadT   misc;     // 047
    logic [3:0] nibble;   // 042 / 043 burst count
  } loadWordT;

endpackage
